//--- source/emio_pkg.sv
// shared constants and types for the processor pin bridge
// address spaces, pin word bit positions, FSM states and the register address word
package emio_pkg;

    // address space codes, found in address bits 15:12
    localparam logic [3:0] space_main = 4'd0;
    localparam logic [3:0] space_hub = 4'd2;

    // hub offset whose write also starts a real-time read
    localparam logic [11:0] hub_rt_reg = 12'h800;

    // version reported in status bits 63:60
    localparam logic [3:0] fw_version = 4'd1;

    // bit positions in the 64-bit pin word
    localparam int emio_data_lo = 0;
    localparam int emio_addr_lo = 32;
    localparam int emio_req = 48;
    localparam int emio_done = 49;
    localparam int emio_wen = 50;
    localparam int emio_blk_start = 51;
    localparam int emio_blk_end = 52;
    localparam int emio_write = 53;
    localparam int emio_grant = 54;
    localparam int emio_lsb = 55;

    typedef enum logic [2:0] {
        st_idle,
        st_read,
        st_write_quad,
        st_write_blk_start,
        st_write_blk_data,
        st_write_finish
    } ctrl_state_t;

    // main space splits the low 12 bits into channel and offset
    typedef struct packed {
        logic [3:0] space;
        logic [3:0] channel;
        logic [7:0] offset;
    } board_addr_t;

    // hub space uses all 12 low bits as one offset
    typedef struct packed {
        logic [3:0]  space;
        logic [11:0] offset;
    } hub_addr_t;

    typedef union packed {
        board_addr_t board;
        hub_addr_t   hub;
    } reg_addr_u;

endpackage

//--- source/emio_sync.sv
// brings the processor pin fields into the sysclk domain
// req gets a two-flop chain and edge pulses, the other fields a single latch
module emio_sync (
    input  logic        sysclk,
    input  logic        rst_n,
    input  logic        ps_req,
    input  logic [15:0] ps_addr,
    input  logic        ps_lsb,
    input  logic        ps_blk_start,
    input  logic        ps_blk_end,
    output logic        req_rise,
    output logic        req_fall,
    output logic [15:0] addr_latched,
    output logic        lsb_latched,
    output logic        blk_start_latched,
    output logic        blk_end_latched,
    output logic        addr_stable
);

    logic req_meta;
    logic req_sync;

    // req chain and registered edge pulses, 2 cycles behind the pin
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            req_meta <= 1'b0;
            req_sync <= 1'b0;
            req_rise <= 1'b0;
            req_fall <= 1'b0;
        end else begin
            req_meta <= ps_req;
            req_sync <= req_meta;
            req_rise <= req_meta & ~req_sync;
            req_fall <= ~req_meta & req_sync;
        end
    end

    // these are held steady by the processor before req rises
    always_ff @(posedge sysclk) begin
        addr_latched <= ps_addr;
        lsb_latched <= ps_lsb;
        blk_start_latched <= ps_blk_start;
        blk_end_latched <= ps_blk_end;
    end

    // live address settled into the latch
    assign addr_stable = (ps_addr == addr_latched);

endmodule

//--- source/emio_ctrl.sv
// control FSM of the pin bridge: bus requests, quadlet and block sequencing
// block transfers advance whenever the processor toggles the address lsb
module emio_ctrl (
    input  logic        sysclk,
    input  logic        rst_n,
    input  logic        req_rise,
    input  logic        req_fall,
    input  logic        is_write,
    input  logic [15:0] addr_latched,
    input  logic        lsb_latched,
    input  logic        blk_start_latched,
    input  logic        blk_end_latched,
    input  logic        addr_stable,
    input  logic [31:0] wdata_in,
    input  logic        grant_read_bus,
    input  logic        grant_write_bus,
    input  logic [31:0] rdata,
    input  logic        rvalid,
    input  logic [31:0] ts_delta,
    output logic [15:0] reg_addr,
    output logic [31:0] reg_wdata,
    output logic        reg_wen,
    output logic        blk_wen,
    output logic        blk_wstart,
    output logic        blk_rt_rd,
    output logic        blk_rt_wr,
    output logic        req_read_bus,
    output logic        req_write_bus,
    output logic        req_blk_rt_rd,
    output logic        ts_capture,
    output logic [31:0] rdata_latched,
    output logic        op_done
);

    emio_pkg::ctrl_state_t state;
    emio_pkg::reg_addr_u   pin_addr;
    emio_pkg::reg_addr_u   cur_addr;

    logic       lsb_saved;   // lsb of the quadlet being worked on
    logic       done_r;
    logic       rd_more;     // keep the read bus after this quadlet
    logic       wen_next;
    logic       done_next;
    logic [1:0] blk_cnt;     // block write beat counter
    logic       first_quad;
    logic       addr_next;
    logic       is_main;
    logic       is_hub_rt;
    logic       rt_start;
    logic       ts_rd;

    assign pin_addr = addr_latched;
    assign cur_addr = reg_addr;

    assign is_main = (pin_addr.board.space == emio_pkg::space_main);
    assign is_hub_rt = (pin_addr.hub.space == emio_pkg::space_hub) &&
                       (pin_addr.hub.offset == emio_pkg::hub_rt_reg);

    // real-time block read, or the hub register write that also kicks one off
    assign rt_start = (~is_write & blk_start_latched & is_main) | (is_write & is_hub_rt);
    assign ts_capture = (state == emio_pkg::st_idle) & req_rise & rt_start;

    // offset 0 of a real-time read is the timestamp delta
    assign ts_rd = blk_rt_rd && (cur_addr.board.offset == 8'd0);

    // processor wrote a new lsb, so the next quadlet is wanted
    assign addr_next = (lsb_latched != lsb_saved);

    // hide done until pins and controller agree on the quadlet
    assign op_done = done_r & addr_stable & ~addr_next;

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            state <= emio_pkg::st_idle;
            req_read_bus <= 1'b0;
            req_write_bus <= 1'b0;
            reg_wen <= 1'b0;
            blk_wen <= 1'b0;
            blk_wstart <= 1'b0;
            blk_rt_rd <= 1'b0;
            blk_rt_wr <= 1'b0;
            req_blk_rt_rd <= 1'b0;
            done_r <= 1'b0;
            lsb_saved <= 1'b0;
            rd_more <= 1'b0;
            wen_next <= 1'b0;
            done_next <= 1'b0;
            blk_cnt <= 2'd0;
            first_quad <= 1'b0;
        end else begin
            // single cycle pulse
            req_blk_rt_rd <= 1'b0;

            case (state)
                emio_pkg::st_idle: begin
                    done_r <= 1'b0;
                    reg_wen <= 1'b0;
                    blk_wen <= 1'b0;
                    blk_wstart <= 1'b0;
                    blk_cnt <= 2'd0;
                    if (req_rise) begin
                        first_quad <= 1'b1;
                        req_blk_rt_rd <= rt_start;
                        lsb_saved <= lsb_latched;
                        if (!is_write) begin
                            req_read_bus <= 1'b1;
                            rd_more <= blk_start_latched & ~blk_end_latched;
                            reg_addr <= addr_latched;
                            blk_rt_rd <= blk_start_latched & is_main;
                            blk_rt_wr <= 1'b0;
                            state <= emio_pkg::st_read;
                        end else begin
                            req_write_bus <= 1'b1;
                            // real-time block write always starts at offset 0
                            reg_addr[15:12] <= pin_addr.hub.space;
                            reg_addr[11:0] <= (blk_start_latched & is_main) ?
                                              12'd0 : pin_addr.hub.offset;
                            blk_rt_rd <= 1'b0;
                            blk_rt_wr <= blk_start_latched & is_main;
                            reg_wdata <= wdata_in;
                            state <= blk_start_latched ? emio_pkg::st_write_blk_start :
                                                         emio_pkg::st_write_quad;
                        end
                    end else begin
                        // let go of the bus
                        req_read_bus <= 1'b0;
                        req_write_bus <= 1'b0;
                    end
                end

                emio_pkg::st_read: begin
                    if (req_read_bus && grant_read_bus) begin
                        if (addr_next) begin
                            done_r <= 1'b0;
                            rd_more <= blk_start_latched & ~blk_end_latched;
                            // done drops one cycle before the address moves on
                            if (!done_r) begin
                                reg_addr[11:0] <= reg_addr[11:0] + 12'd1;
                                lsb_saved <= lsb_latched;
                            end
                        end else if (rvalid) begin
                            rdata_latched <= ts_rd ? ts_delta : rdata;
                            done_r <= 1'b1;
                            req_read_bus <= rd_more;
                        end
                    end
                    // left only through the req falling edge
                end

                emio_pkg::st_write_quad: begin
                    if (req_write_bus && grant_write_bus) begin
                        reg_wen <= 1'b1;
                        blk_wen <= 1'b1;
                        state <= emio_pkg::st_write_finish;
                    end
                end

                emio_pkg::st_write_blk_start: begin
                    // 4-cycle wstart preamble, restarted if the grant drops
                    if (req_write_bus && grant_write_bus) begin
                        blk_wstart <= 1'b1;
                        blk_cnt <= blk_cnt + 2'd1;
                        if (blk_cnt == 2'd3) begin
                            state <= emio_pkg::st_write_blk_data;
                        end
                    end else begin
                        blk_cnt <= 2'd0;
                    end
                end

                emio_pkg::st_write_blk_data: begin
                    if (req_write_bus && grant_write_bus) begin
                        blk_wstart <= 1'b0;
                        if (first_quad) begin
                            // data for the first quadlet came with the request
                            first_quad <= 1'b0;
                            reg_wen <= 1'b1;
                            wen_next <= 1'b0;
                            done_next <= ~blk_end_latched;
                            blk_cnt <= 2'd1;
                        end else if (addr_next) begin
                            reg_wdata <= wdata_in;
                            reg_wen <= 1'b0;
                            wen_next <= 1'b1;
                            done_r <= 1'b0;
                            done_next <= ~blk_end_latched;
                            blk_cnt <= 2'd0;
                            if (!done_r) begin
                                reg_addr[11:0] <= reg_addr[11:0] + 12'd1;
                                lsb_saved <= lsb_latched;
                            end
                        end else begin
                            // 2-cycle spacing before each following wen
                            reg_wen <= wen_next;
                            wen_next <= 1'b0;
                            done_r <= done_next & ~wen_next;
                            blk_cnt <= blk_cnt + 2'd1;
                            // last quadlet closes the block
                            if (blk_cnt == 2'd3 && !done_next) begin
                                blk_wen <= 1'b1;
                                state <= emio_pkg::st_write_finish;
                            end
                        end
                    end else begin
                        blk_cnt <= 2'd0;
                    end
                end

                emio_pkg::st_write_finish: begin
                    reg_wen <= 1'b0;
                    blk_wen <= 1'b0;
                    req_write_bus <= 1'b0;
                    done_r <= 1'b1;
                end

                default: state <= emio_pkg::st_idle;
            endcase

            // req falling edge ends or aborts any transfer
            if (req_fall) begin
                state <= emio_pkg::st_idle;
            end
        end
    end

endmodule

//--- source/write_addr_xlate.sv
// write address translation for real-time block writes
// header quadlet checks the board id, data quadlet k goes to channel k offset 0
module write_addr_xlate (
    input  logic        sysclk,
    input  logic        rst_n,
    input  logic [15:0] waddr_in,
    input  logic        wen_in,
    input  logic        blk_rt_wr,
    input  logic [31:0] wdata,
    input  logic [3:0]  board_id,
    output logic [15:0] waddr_out,
    output logic        wen_out
);

    emio_pkg::reg_addr_u addr_in;
    logic is_header;
    logic hdr_match;

    assign addr_in = waddr_in;
    assign is_header = blk_rt_wr && (addr_in.board.offset == 8'd0);

    // header bits 11:8 carry the target board
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            hdr_match <= 1'b0;
        end else if (is_header && wen_in) begin
            hdr_match <= (wdata[11:8] == board_id);
        end
    end

    assign waddr_out = blk_rt_wr ?
                       {emio_pkg::space_main, addr_in.board.offset[3:0], 8'd0} : waddr_in;

    // no write for the header, data only when the header matched
    assign wen_out = blk_rt_wr ? (wen_in & ~is_header & hdr_match) : wen_in;

endmodule

//--- source/timestamp_delta.sv
// timestamp difference between successive real-time requests
// delta updates the cycle after capture
module timestamp_delta #(
    parameter int TS_W = 32
) (
    input  logic            sysclk,
    input  logic            rst_n,
    input  logic            capture,
    input  logic [TS_W-1:0] timestamp,
    output logic [TS_W-1:0] delta
);

    logic [TS_W-1:0] ts_prev;

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            ts_prev <= '0;
        end else if (capture) begin
            ts_prev <= timestamp;
        end
    end

    // elapsed ticks since the last capture, less one
    always_ff @(posedge sysclk) begin
        if (capture) begin
            delta <= timestamp - ts_prev - TS_W'(1);
        end
    end

endmodule

//--- source/reg_bank.sv
// stand-in for the board register bus: word memory with bus grants
// reads become valid RD_LATENCY cycles after a stable granted address
module reg_bank #(
    parameter int BANK_WORDS = 64,
    parameter int RD_LATENCY = 2
) (
    input  logic        sysclk,
    input  logic        rst_n,
    input  logic        req_read_bus,
    input  logic        req_write_bus,
    input  logic [15:0] raddr,
    input  logic [15:0] waddr,
    input  logic [31:0] wdata,
    input  logic        wen,
    output logic        grant_read_bus,
    output logic        grant_write_bus,
    output logic [31:0] rdata,
    output logic        rvalid
);

    localparam int IDX_W = $clog2(BANK_WORDS);
    localparam int CH_W = IDX_W / 2;
    localparam int OFF_W = IDX_W - CH_W;
    localparam int CNT_W = $clog2(RD_LATENCY + 1);

    emio_pkg::reg_addr_u ra;
    emio_pkg::reg_addr_u wa;

    logic [31:0]      mem [BANK_WORDS];
    logic [IDX_W-1:0] ridx;
    logic [IDX_W-1:0] widx;
    logic [15:0]      raddr_q;
    logic [CNT_W-1:0] lat_cnt;

    assign ra = raddr;
    assign wa = waddr;

    // space bits dropped, low bits of channel and offset form the word index
    assign ridx = {ra.board.channel[CH_W-1:0], ra.board.offset[OFF_W-1:0]};
    assign widx = {wa.board.channel[CH_W-1:0], wa.board.offset[OFF_W-1:0]};

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            for (int i = 0; i < BANK_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (wen) begin
            mem[widx] <= wdata;
        end
    end

    always_ff @(posedge sysclk) begin
        rdata <= mem[ridx];
    end

    // one-cycle grants, held while the request stays up
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            grant_read_bus <= 1'b0;
            grant_write_bus <= 1'b0;
            raddr_q <= '0;
            lat_cnt <= '0;
        end else begin
            grant_read_bus <= req_read_bus;
            grant_write_bus <= req_write_bus;
            raddr_q <= raddr;
            // a new address restarts the read delay
            if (!grant_read_bus || raddr != raddr_q) begin
                lat_cnt <= '0;
            end else if (lat_cnt != CNT_W'(RD_LATENCY)) begin
                lat_cnt <= lat_cnt + 1'b1;
            end
        end
    end

    // drops at once when the address moves
    assign rvalid = grant_read_bus && (raddr == raddr_q) && (lat_cnt == CNT_W'(RD_LATENCY));

endmodule

//--- source/emio_top.sv
// pin bridge top: splits the processor pin word, wires sync, FSM, translator,
// timestamp and register bank, and builds the status word
module emio_top #(
    parameter int BANK_WORDS = 64,
    parameter int RD_LATENCY = 2
) (
    input  logic        sysclk,
    input  logic        rst_n,
    input  logic [3:0]  board_id,
    input  logic [63:0] emio_ps_out,
    input  logic [63:0] emio_ps_tri,
    input  logic [31:0] timestamp,
    output logic [63:0] emio_ps_in,
    output logic        blk_wen,
    output logic        blk_wstart,
    output logic        req_blk_rt_rd,
    output logic        blk_rt_rd,
    output logic        blk_rt_wr
);

    logic [31:0] ps_wdata;
    logic [15:0] ps_addr;
    logic        ps_req;
    logic        ps_wen;
    logic        ps_blk_start;
    logic        ps_blk_end;
    logic        ps_lsb;
    logic        is_write;

    logic        req_rise;
    logic        req_fall;
    logic [15:0] addr_latched;
    logic        lsb_latched;
    logic        blk_start_latched;
    logic        blk_end_latched;
    logic        addr_stable;

    logic [15:0] reg_addr;
    logic [31:0] reg_wdata;
    logic        reg_wen;
    logic [15:0] reg_waddr;
    logic        reg_wen_out;
    logic        req_read_bus;
    logic        req_write_bus;
    logic        grant_read_bus;
    logic        grant_write_bus;
    logic [31:0] rdata;
    logic        rvalid;
    logic [31:0] rdata_latched;
    logic        op_done;
    logic        ts_capture;
    logic [31:0] ts_delta;

    assign ps_wdata = emio_ps_out[emio_pkg::emio_data_lo +: 32];
    assign ps_addr = emio_ps_out[emio_pkg::emio_addr_lo +: 16];
    assign ps_req = emio_ps_out[emio_pkg::emio_req];
    assign ps_wen = emio_ps_out[emio_pkg::emio_wen];
    assign ps_blk_start = emio_ps_out[emio_pkg::emio_blk_start];
    assign ps_blk_end = emio_ps_out[emio_pkg::emio_blk_end];
    assign ps_lsb = emio_ps_out[emio_pkg::emio_lsb];

    // processor drives all data lines on a write
    assign is_write = (emio_ps_tri[31:0] == 32'd0);

    emio_sync u_sync (
        .sysclk(sysclk), .rst_n(rst_n), .ps_req(ps_req), .ps_addr(ps_addr),
        .ps_lsb(ps_lsb), .ps_blk_start(ps_blk_start), .ps_blk_end(ps_blk_end),
        .req_rise(req_rise), .req_fall(req_fall), .addr_latched(addr_latched),
        .lsb_latched(lsb_latched), .blk_start_latched(blk_start_latched),
        .blk_end_latched(blk_end_latched), .addr_stable(addr_stable)
    );

    emio_ctrl u_ctrl (
        .sysclk(sysclk), .rst_n(rst_n), .req_rise(req_rise), .req_fall(req_fall),
        .is_write(is_write), .addr_latched(addr_latched), .lsb_latched(lsb_latched),
        .blk_start_latched(blk_start_latched), .blk_end_latched(blk_end_latched),
        .addr_stable(addr_stable), .wdata_in(ps_wdata),
        .grant_read_bus(grant_read_bus), .grant_write_bus(grant_write_bus),
        .rdata(rdata), .rvalid(rvalid), .ts_delta(ts_delta),
        .reg_addr(reg_addr), .reg_wdata(reg_wdata), .reg_wen(reg_wen),
        .blk_wen(blk_wen), .blk_wstart(blk_wstart), .blk_rt_rd(blk_rt_rd),
        .blk_rt_wr(blk_rt_wr), .req_read_bus(req_read_bus), .req_write_bus(req_write_bus),
        .req_blk_rt_rd(req_blk_rt_rd), .ts_capture(ts_capture),
        .rdata_latched(rdata_latched), .op_done(op_done)
    );

    write_addr_xlate u_xlate (
        .sysclk(sysclk), .rst_n(rst_n), .waddr_in(reg_addr), .wen_in(reg_wen),
        .blk_rt_wr(blk_rt_wr), .wdata(reg_wdata), .board_id(board_id),
        .waddr_out(reg_waddr), .wen_out(reg_wen_out)
    );

    timestamp_delta #(.TS_W(32)) u_ts (
        .sysclk(sysclk), .rst_n(rst_n), .capture(ts_capture),
        .timestamp(timestamp), .delta(ts_delta)
    );

    reg_bank #(.BANK_WORDS(BANK_WORDS), .RD_LATENCY(RD_LATENCY)) u_bank (
        .sysclk(sysclk), .rst_n(rst_n), .req_read_bus(req_read_bus),
        .req_write_bus(req_write_bus), .raddr(reg_addr), .waddr(reg_waddr),
        .wdata(reg_wdata), .wen(reg_wen_out), .grant_read_bus(grant_read_bus),
        .grant_write_bus(grant_write_bus), .rdata(rdata), .rvalid(rvalid)
    );

    // status word back to the processor, unused bits read as zero
    always_comb begin
        emio_ps_in = '0;
        emio_ps_in[63:60] = emio_pkg::fw_version;
        emio_ps_in[emio_pkg::emio_lsb] = ps_lsb;
        emio_ps_in[emio_pkg::emio_grant] = is_write ? grant_write_bus : grant_read_bus;
        emio_ps_in[emio_pkg::emio_write] = is_write;
        emio_ps_in[emio_pkg::emio_blk_end] = ps_blk_end;
        emio_ps_in[emio_pkg::emio_blk_start] = ps_blk_start;
        emio_ps_in[emio_pkg::emio_wen] = ps_wen;
        emio_ps_in[emio_pkg::emio_done] = op_done;
        emio_ps_in[emio_pkg::emio_req] = ps_req;
        emio_ps_in[emio_pkg::emio_addr_lo +: 16] = ps_addr;
        emio_ps_in[emio_pkg::emio_data_lo +: 32] = is_write ? ps_wdata : rdata_latched;
    end

endmodule

//--- tests/tb_emio.sv
// directed testbench for the processor pin bridge
// drives the pin word the way the processor does and checks the status word
module tb_emio;

    // about 25 requests of well under 100 cycles each, with margin
    localparam int max_cycles = 4000;
    localparam logic [3:0] exp_version = 4'h1;
    localparam logic [3:0] my_board = 4'h5;

    logic        sysclk;
    logic        rst_n;
    logic [3:0]  board_id;
    logic [63:0] emio_ps_out;
    logic [63:0] emio_ps_tri;
    logic [31:0] timestamp;
    logic [63:0] emio_ps_in;
    logic        blk_wen;
    logic        blk_wstart;
    logic        req_blk_rt_rd;
    logic        blk_rt_rd;
    logic        blk_rt_wr;

    int          cycle_cnt = 0;
    int          rt_pulses = 0;
    int          wstart_cycles = 0;
    int          blk_wen_cycles = 0;
    logic        rt_rd_seen;
    logic        rt_wr_seen;
    logic [31:0] ts_prev;      // timestamp at the last real-time capture
    logic [31:0] blk_wr_data [8];
    logic [31:0] blk_rd_data [8];

    emio_top DUT (
        .sysclk(sysclk), .rst_n(rst_n), .board_id(board_id),
        .emio_ps_out(emio_ps_out), .emio_ps_tri(emio_ps_tri), .timestamp(timestamp),
        .emio_ps_in(emio_ps_in), .blk_wen(blk_wen), .blk_wstart(blk_wstart),
        .req_blk_rt_rd(req_blk_rt_rd), .blk_rt_rd(blk_rt_rd), .blk_rt_wr(blk_rt_wr)
    );

    always #2 sysclk = ~sysclk;

    // run limit
    always @(posedge sysclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= max_cycles) begin
            $display("run timed out after %0d cycles, a transfer never finished", cycle_cnt);
            $display("Result: FAILED");
            $fatal(1);
        end
    end

    // real-time read pulse and block framing strobes, counted per cycle
    always @(negedge sysclk) begin
        if (req_blk_rt_rd) begin
            rt_pulses <= rt_pulses + 1;
        end
        if (blk_wstart) begin
            wstart_cycles <= wstart_cycles + 1;
        end
        if (blk_wen) begin
            blk_wen_cycles <= blk_wen_cycles + 1;
        end
    end

    task automatic check_val(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            $display("Result: FAILED");
            $fatal(1);
        end
    endtask

    // new request on the pins, called at a falling edge
    task automatic start_request(input logic [15:0] addr, input logic [31:0] data,
                                 input logic write, input logic blk);
        emio_ps_out[emio_pkg::emio_addr_lo +: 16] = addr;
        emio_ps_out[emio_pkg::emio_data_lo +: 32] = data;
        emio_ps_out[emio_pkg::emio_wen] = write;
        emio_ps_out[emio_pkg::emio_blk_start] = blk;
        emio_ps_out[emio_pkg::emio_blk_end] = 1'b0;
        emio_ps_out[emio_pkg::emio_req] = 1'b1;
        // all data lines driven means write
        emio_ps_tri[31:0] = write ? 32'd0 : 32'hffff_ffff;
    endtask

    task automatic wait_done();
        @(negedge sysclk);
        while (!emio_ps_in[emio_pkg::emio_done]) begin
            @(negedge sysclk);
        end
    endtask

    // drop req, then let the synchronizer see it low before the next request
    task automatic end_request();
        emio_ps_out[emio_pkg::emio_req] = 1'b0;
        @(negedge sysclk);
        while (emio_ps_in[emio_pkg::emio_done]) begin
            @(negedge sysclk);
        end
        repeat (2) @(negedge sysclk);
    endtask

    task automatic ps_write(input logic [15:0] addr, input logic [31:0] data);
        start_request(addr, data, 1'b1, 1'b0);
        wait_done();
        check_val("write flag", 32'(emio_ps_in[emio_pkg::emio_write]), 32'd1);
        check_val("write data echo", emio_ps_in[31:0], data);
        end_request();
    endtask

    task automatic ps_read(input logic [15:0] addr, output logic [31:0] data);
        start_request(addr, 32'd0, 1'b0, 1'b0);
        wait_done();
        data = emio_ps_in[31:0];
        end_request();
    endtask

    // n sequential quadlets, only lsb toggles between them
    task automatic ps_block(input logic [15:0] addr, input logic write, input int n);
        int i;
        start_request(addr, write ? blk_wr_data[0] : 32'd0, write, 1'b1);
        emio_ps_out[emio_pkg::emio_blk_end] = (n == 1);
        wait_done();
        rt_rd_seen = blk_rt_rd;
        rt_wr_seen = blk_rt_wr;
        blk_rd_data[0] = emio_ps_in[31:0];
        for (i = 1; i < n; i++) begin
            emio_ps_out[emio_pkg::emio_lsb] = ~emio_ps_out[emio_pkg::emio_lsb];
            if (write) begin
                emio_ps_out[emio_pkg::emio_data_lo +: 32] = blk_wr_data[i];
            end
            emio_ps_out[emio_pkg::emio_blk_end] = (i == n - 1);
            wait_done();
            check_val("lsb echo", 32'(emio_ps_in[emio_pkg::emio_lsb]),
                      32'(emio_ps_out[emio_pkg::emio_lsb]));
            blk_rd_data[i] = emio_ps_in[31:0];
        end
        end_request();
    endtask

    task automatic quadlet_write_read();
        logic [31:0] wr;
        wr = $urandom();
        ps_write(16'h2006, wr);
        start_request(16'h2006, 32'd0, 1'b0, 1'b0);
        wait_done();
        check_val("quadlet read data", emio_ps_in[31:0], wr);
        check_val("address echo", 32'(emio_ps_in[47:32]), 32'h2006);
        check_val("version", 32'(emio_ps_in[63:60]), 32'(exp_version));
        end_request();
    endtask

    task automatic block_read_in_order();
        logic [31:0] words [4];
        int i;
        int pulses_before;
        for (i = 0; i < 4; i++) begin
            words[i] = $urandom();
            ps_write(16'h2001 + 16'(i), words[i]);
        end
        pulses_before = rt_pulses;
        ps_block(16'h2001, 1'b0, 4);
        // hub space block is not real-time
        check_val("hub block rt pulses", 32'(rt_pulses - pulses_before), 32'd0);
        check_val("hub block blk_rt_rd", 32'(rt_rd_seen), 32'd0);
        for (i = 0; i < 4; i++) begin
            check_val($sformatf("block read word %0d", i), blk_rd_data[i], words[i]);
        end
    endtask

    task automatic rt_read_delta();
        logic [31:0] words [4];
        logic [31:0] delta_exp;
        int i;
        int run;
        int pulses_before;
        for (i = 1; i < 4; i++) begin
            words[i] = $urandom();
            ps_write(16'(i), words[i]);
        end
        for (run = 0; run < 2; run++) begin
            // timestamp held still for the whole block
            timestamp = $urandom();
            delta_exp = timestamp - ts_prev - 32'd1;
            pulses_before = rt_pulses;
            ps_block(16'h0000, 1'b0, 4);
            ts_prev = timestamp;
            check_val("req_blk_rt_rd pulses", 32'(rt_pulses - pulses_before), 32'd1);
            check_val("blk_rt_rd", 32'(rt_rd_seen), 32'd1);
            check_val("rt read delta", blk_rd_data[0], delta_exp);
            for (i = 1; i < 4; i++) begin
                check_val($sformatf("rt read word %0d", i), blk_rd_data[i], words[i]);
            end
        end
    endtask

    task automatic rt_write_gating();
        logic [31:0] kept [4];
        logic [31:0] rd;
        logic [31:0] hdr_word;
        int k;
        int wstart_before;
        int wen_before;
        // the header quadlet itself must never reach the bank
        ps_read(16'h0000, hdr_word);
        // header bits 11:8 carry the target board
        blk_wr_data[0] = ($urandom() & 32'hffff_f0ff) | (32'(my_board) << 8);
        for (k = 1; k < 4; k++) begin
            blk_wr_data[k] = $urandom();
        end
        wstart_before = wstart_cycles;
        wen_before = blk_wen_cycles;
        ps_block(16'h0000, 1'b1, 4);
        check_val("blk_rt_wr", 32'(rt_wr_seen), 32'd1);
        // 4-cycle wstart preamble, one end-of-block wen strobe
        check_val("blk_wstart cycles", 32'(wstart_cycles - wstart_before), 32'd4);
        check_val("blk_wen strobes", 32'(blk_wen_cycles - wen_before), 32'd1);
        for (k = 1; k < 4; k++) begin
            ps_read(16'(k * 256), rd);
            check_val($sformatf("rt write channel %0d", k), rd, blk_wr_data[k]);
            kept[k] = rd;
        end
        // other board, data must be dropped
        blk_wr_data[0] = ($urandom() & 32'hffff_f0ff) | (32'(my_board ^ 4'h3) << 8);
        for (k = 1; k < 4; k++) begin
            blk_wr_data[k] = $urandom();
        end
        ps_block(16'h0000, 1'b1, 4);
        for (k = 1; k < 4; k++) begin
            ps_read(16'(k * 256), rd);
            check_val($sformatf("gated write channel %0d", k), rd, kept[k]);
        end
        ps_read(16'h0000, rd);
        check_val("rt header word", rd, hdr_word);
    endtask

    task automatic abort_then_recover();
        logic [31:0] kept;
        logic [31:0] rd;
        logic [31:0] wr;
        int i;
        ps_read(16'h2006, kept);
        // hub block write, aborted during its wstart preamble
        start_request(16'h2006, $urandom(), 1'b1, 1'b1);
        @(negedge sysclk);
        while (!emio_ps_in[emio_pkg::emio_grant]) begin
            @(negedge sysclk);
        end
        check_val("op_done at abort", 32'(emio_ps_in[emio_pkg::emio_done]), 32'd0);
        check_val("hub block blk_rt_wr", 32'(blk_rt_wr), 32'd0);
        emio_ps_out[emio_pkg::emio_req] = 1'b0;
        @(negedge sysclk);
        while (emio_ps_in[emio_pkg::emio_done] || emio_ps_in[emio_pkg::emio_grant]) begin
            @(negedge sysclk);
        end
        // both stay low once idle
        for (i = 0; i < 4; i++) begin
            @(negedge sysclk);
            check_val("op_done after abort", 32'(emio_ps_in[emio_pkg::emio_done]), 32'd0);
            check_val("grant after abort", 32'(emio_ps_in[emio_pkg::emio_grant]), 32'd0);
        end
        ps_read(16'h2006, rd);
        check_val("word after abort", rd, kept);
        wr = $urandom();
        ps_write(16'h2007, wr);
        ps_read(16'h2007, rd);
        check_val("quadlet after abort", rd, wr);
    endtask

    initial begin
        sysclk = 1'b0;
        rst_n = 1'b0;
        board_id = my_board;
        emio_ps_out = '0;
        emio_ps_tri = '1;
        timestamp = '0;
        ts_prev = '0;
        void'($urandom(32'hacb60c93));
        repeat (10) @(negedge sysclk);
        rst_n = 1'b1;
        repeat (2) @(negedge sysclk);

        quadlet_write_read();
        block_read_in_order();
        rt_read_delta();
        rt_write_gating();
        abort_then_recover();

        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- vlog.f
source/emio_pkg.sv
source/emio_sync.sv
source/emio_ctrl.sv
source/write_addr_xlate.sv
source/timestamp_delta.sv
source/reg_bank.sv
source/emio_top.sv
tests/tb_emio.sv

//--- run.sh
#!/bin/sh
# build the bridge testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_emio -Mdir obj_dir -f vlog.f
out=$(./obj_dir/Vtb_emio 2>&1) || true
echo "$out"
if echo "$out" | grep -q "Result: PASSED"; then
    exit 0
fi
exit 1
